// ==== vlog.f ====
accel_pkg.sv
layer_cmd_if.sv
sync_fifo.sv
burst_packer.sv
tile_ram.sv
csb.sv
gemm_engine.sv
accel_top.sv
tb_clkgen.sv
tb_accel.sv

// ==== Bender.yml ====
package:
  name: accel

sources:
  - accel_pkg.sv
  - layer_cmd_if.sv
  - sync_fifo.sv
  - burst_packer.sv
  - tile_ram.sv
  - csb.sv
  - gemm_engine.sv
  - accel_top.sv
  - target: simulation
    files:
      - tb_clkgen.sv
      - tb_accel.sv

// ==== tb_accel.sv ====
`default_nettype none

module tb_accel
	import accel_pkg::*;
();

	localparam int CLK_PERIOD = 8;
	localparam int MAX_IN     = 8;
	localparam int MAX_OUT    = 8;
	localparam int N_LAYERS   = 9;	// tests 2 to 6 together
	// writes, compute and pops of the largest layer plus slack
	localparam int LAYER_CYCLES = BURST_LEN * MAX_IN * (MAX_OUT + 1) + MAX_OUT
		+ MAX_OUT * (MAX_IN + 3) + 3 * MAX_OUT + 40;
	localparam int WATCHDOG_CYCLES = 2 * N_LAYERS * LAYER_CYCLES;

	logic okClk;
	logic rst;

	logic              i_cmd_we;
	logic [31:0]       i_cmd;
	logic              i_d_we;
	logic [LANE_W-1:0] i_d;
	logic              i_w_we;
	logic [LANE_W-1:0] i_w;
	logic              i_b_we;
	logic [LANE_W-1:0] i_b;
	logic              i_buf_clr;
	logic              i_res_rd;
	logic              o_res_valid;
	logic [LANE_W-1:0] o_res;
	logic              o_res_empty;
	logic              o_irq;
	logic [6:0]        o_done_count;

	// mirror of the three buffers with one entry per 16-bit value
	logic [LANE_W-1:0] d_val [1024];
	logic [LANE_W-1:0] w_val [16384];
	logic [LANE_W-1:0] b_val [256];
	int d_wp;
	int w_wp;
	int b_wp;

	logic [LANE_W-1:0] exp_q [$];
	logic [31:0] lfsr_q;
	int checks;
	int errors;
	int res_idx;
	int irq_seen;
	int done_exp;
	int relu_zeros;

	tb_clkgen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(2)) clkgen_i (
		.o_clk (okClk),
		.o_rst (rst)
	);

	accel_top dut_i (
		.okClk(okClk), .i_rst(rst), .i_cmd_we(i_cmd_we), .i_cmd(i_cmd),
		.i_d_we(i_d_we), .i_d(i_d), .i_w_we(i_w_we), .i_w(i_w),
		.i_b_we(i_b_we), .i_b(i_b), .i_buf_clr(i_buf_clr), .i_res_rd(i_res_rd),
		.o_res_valid(o_res_valid), .o_res(o_res), .o_res_empty(o_res_empty),
		.o_irq(o_irq), .o_done_count(o_done_count)
	);

	// 32-bit fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			r = {r[30:0], lfsr_q[0]};
		end
		return r;
	endfunction

	// dot product plus bias shifted right before relu
	function automatic int shifted_sum(input logic [4:0] shift, input int n_in,
			input int w_base, input int k);
		int acc;
		int wi;
		acc = 0;
		for (int b = 0; b < n_in; b++) begin
			wi = (w_base + k * n_in + b) * BURST_LEN;
			for (int l = 0; l < BURST_LEN; l++)
				acc = acc + int'($signed(d_val[b * BURST_LEN + l]))
					* int'($signed(w_val[wi + l]));
		end
		acc = acc + int'($signed(b_val[k]));
		return acc >>> shift;
	endfunction

	task automatic put_value(input int kind, input logic [LANE_W-1:0] v);
		@(posedge okClk);
		i_d_we <= 1'b0;
		i_w_we <= 1'b0;
		i_b_we <= 1'b0;
		case (kind)
			0: begin
				i_d_we <= 1'b1;
				i_d    <= v;
				d_val[d_wp] = v;
				d_wp++;
			end
			1: begin
				i_w_we <= 1'b1;
				i_w    <= v;
				w_val[w_wp] = v;
				w_wp++;
			end
			default: begin
				i_b_we <= 1'b1;
				i_b    <= v;
				b_val[b_wp] = v;
				b_wp++;
			end
		endcase
	endtask

	task automatic end_writes();
		@(posedge okClk);
		i_d_we <= 1'b0;
		i_w_we <= 1'b0;
		i_b_we <= 1'b0;
	endtask

	task automatic clear_buffers();
		@(posedge okClk);
		i_buf_clr <= 1'b1;
		@(posedge okClk);
		i_buf_clr <= 1'b0;
		d_wp = 0;
		w_wp = 0;
		b_wp = 0;
	endtask

	// skewed data is small and positive
	task automatic fill_data(input int n_bursts, input bit skew);
		for (int i = 0; i < n_bursts * BURST_LEN; i++)
			put_value(0, skew ? 16'(rand_bits(7)) : 16'(rand_bits(16)));
	endtask

	// skewed weights are small and negative
	task automatic fill_weights(input int n_words, input bit skew, output int base);
		base = w_wp / BURST_LEN;
		for (int i = 0; i < n_words * BURST_LEN; i++)
			put_value(1, skew ? 16'(-int'(rand_bits(7))) : 16'(rand_bits(16)));
	endtask

	task automatic fill_bias(input int n);
		for (int i = 0; i < n; i++)
			put_value(2, 16'(rand_bits(16)));
	endtask

	task automatic issue_layer(input op_t op, input logic [4:0] shift, input int n_in,
			input int n_out, input int w_base);
		logic [31:0] w0;
		logic [31:0] w1;
		int sh;
		w0 = rand_bits(32);	// junk in the ignored bits
		w1 = rand_bits(32);
		w0[31:29] = op;
		w0[28:24] = shift;
		w0[15:8]  = 8'(n_in);
		w0[7:0]   = 8'(n_out);
		w1[11:0]  = 12'(w_base);
		for (int k = 0; k < n_out; k++) begin
			sh = shifted_sum(shift, n_in, w_base, k);
			if (op == OP_FC_RELU && sh < 0) begin
				exp_q.push_back('0);
				relu_zeros++;
			end else begin
				exp_q.push_back(sh[LANE_W-1:0]);
			end
		end
		@(posedge okClk);
		i_cmd_we <= 1'b1;
		i_cmd    <= w0;
		@(posedge okClk);
		i_cmd    <= w1;
		@(posedge okClk);
		i_cmd_we <= 1'b0;
	endtask

	// pops only while the fifo holds data
	task automatic drain_results();
		while (exp_q.size() > 0) begin
			@(negedge okClk);
			if (!o_res_empty) begin
				@(posedge okClk);
				i_res_rd <= 1'b1;
				@(posedge okClk);
				i_res_rd <= 1'b0;
				@(negedge okClk);	// popped word due one cycle after the read
				checks++;
				assert (o_res_valid === 1'b1) else begin
					errors++;
					$display("a pop at %0t gave no result one cycle later", $time);
				end
			end
		end
	endtask

	task automatic wait_irqs(input int target);
		while (irq_seen < target)
			@(negedge okClk);
		repeat (4) @(negedge okClk);	// catch extra pulses
		checks++;
		assert (irq_seen == target && o_done_count == 7'(target)) else begin
			errors++;
			$display("MISMATCH at %0t: irq pulses %0d done count %0d expected %0d",
				$time, irq_seen, o_done_count, target);
		end
	endtask

	task automatic run_layer(input op_t op, input bit skew);
		int n_in;
		int n_out;
		int base;
		n_in  = 1 + int'(rand_bits(3));
		n_out = 1 + int'(rand_bits(3));
		clear_buffers();
		fill_data(n_in, skew);
		fill_weights(n_out * n_in, skew, base);
		fill_bias(n_out);
		end_writes();
		issue_layer(op, 5'(rand_bits(4)), n_in, n_out, base);
		drain_results();
		done_exp++;
		wait_irqs(done_exp);
	endtask

	// results and irq pulses seen away from the clock edge
	always @(negedge okClk) begin
		if (!rst) begin
			if (o_irq)
				irq_seen++;
			if (o_res_valid) begin
				checks++;
				if (exp_q.size() == 0) begin
					assert (0) else begin
						errors++;
						$display("a result came out at %0t with none expected", $time);
					end
				end else begin
					assert (o_res === exp_q[0]) else begin
						errors++;
						$display("MISMATCH at %0t: result %0d got %h expected %h",
							$time, res_idx, o_res, exp_q[0]);
					end
					void'(exp_q.pop_front());
				end
				res_idx++;
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("checks %0d, errors %0d", checks, errors);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		int n_in;
		int na;
		int nb;
		int base_a;
		int base_b;
		logic [4:0] sh_b;
		i_cmd_we  = 1'b0;
		i_cmd     = '0;
		i_d_we    = 1'b0;
		i_d       = '0;
		i_w_we    = 1'b0;
		i_w       = '0;
		i_b_we    = 1'b0;
		i_b       = '0;
		i_buf_clr = 1'b0;
		i_res_rd  = 1'b0;
		lfsr_q    = 32'd83795;
		checks    = 0;
		errors    = 0;
		res_idx   = 0;
		irq_seen  = 0;
		done_exp  = 0;
		wait (!rst);
		@(negedge okClk);

		// reset state
		checks++;
		assert (o_res_empty === 1'b1 && o_done_count === 7'd0 && o_irq === 1'b0
				&& o_res_valid === 1'b0) else begin
			errors++;
			$display("MISMATCH at %0t: reset state empty %b count %0d irq %b valid %b",
				$time, o_res_empty, o_done_count, o_irq, o_res_valid);
		end

		run_layer(OP_FC, 1'b0);

		relu_zeros = 0;
		run_layer(OP_FC_RELU, 1'b1);
		checks++;
		assert (relu_zeros > 0) else begin
			errors++;
			$display("relu layer produced no negative sum to clip");
		end

		repeat (4) run_layer(OP_FC, 1'b0);	// shift sweep

		// two layers queued back to back
		n_in = 1 + int'(rand_bits(3));
		na   = 1 + int'(rand_bits(3));
		nb   = 1 + int'(rand_bits(3));
		sh_b = 5'(rand_bits(4));
		clear_buffers();
		fill_data(n_in, 1'b0);
		fill_weights(na * n_in, 1'b0, base_a);
		fill_weights(nb * n_in, 1'b0, base_b);
		fill_bias((na > nb) ? na : nb);
		end_writes();
		issue_layer(OP_FC, 5'(rand_bits(4)), n_in, na, base_a);
		issue_layer(OP_FC, sh_b, n_in, nb, base_b);
		drain_results();
		done_exp += 2;
		wait_irqs(done_exp);

		// new vector at address 0 with old weights and biases kept
		clear_buffers();
		fill_data(n_in, 1'b0);
		end_writes();
		issue_layer(OP_FC, sh_b, n_in, nb, base_b);
		drain_results();
		done_exp++;
		wait_irqs(done_exp);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb_clkgen.sv ====
`default_nettype none

module tb_clkgen #(
	parameter int PERIOD     = 8,
	parameter int RST_CYCLES = 2
) (
	output logic o_clk,
	output logic o_rst
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD / 2) o_clk = ~o_clk;
	end

	// synchronous reset, released on a rising edge
	initial begin
		o_rst = 1'b1;
		repeat (RST_CYCLES) @(posedge o_clk);
		o_rst <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== accel_top.sv ====
`default_nettype none

module accel_top
	import accel_pkg::*;
(
	input  wire logic              okClk,
	input  wire logic              i_rst,
	input  wire logic              i_cmd_we,
	input  wire logic [31:0]       i_cmd,
	input  wire logic              i_d_we,
	input  wire logic [LANE_W-1:0] i_d,
	input  wire logic              i_w_we,
	input  wire logic [LANE_W-1:0] i_w,
	input  wire logic              i_b_we,
	input  wire logic [LANE_W-1:0] i_b,
	input  wire logic              i_buf_clr,
	input  wire logic              i_res_rd,
	output logic                   o_res_valid,
	output logic [LANE_W-1:0]      o_res,
	output logic                   o_res_empty,
	output logic                   o_irq,
	output logic [6:0]             o_done_count
);

	logic [31:0] cmd_word;
	logic        cmd_valid;
	logic        cmd_empty;
	logic        cmd_pop;

	// buffer write side
	logic              d_we;
	logic [D_AW-1:0]   d_waddr;
	logic [WORD_W-1:0] d_wdata;
	logic              w_we;
	logic [W_AW-1:0]   w_waddr;
	logic [WORD_W-1:0] w_wdata;
	logic              b_we;
	logic [B_AW-1:0]   b_waddr;
	logic [LANE_W-1:0] b_wdata;

	// engine read side
	logic [D_AW-1:0]   d_raddr;
	logic [WORD_W-1:0] d_rdata;
	logic [W_AW-1:0]   w_raddr;
	logic [WORD_W-1:0] w_rdata;
	logic [B_AW-1:0]   b_raddr;
	logic [LANE_W-1:0] b_rdata;

	logic              res_we;
	logic [LANE_W-1:0] res_data;

	layer_cmd_if cmd_if ();

	sync_fifo #(.payload_t(logic [31:0]), .DEPTH(CMD_DEPTH)) cmd_fifo_i (
		.okClk   (okClk),
		.i_rst   (i_rst),
		.i_push  (i_cmd_we),
		.i_din   (i_cmd),
		.i_pop   (cmd_pop),
		.o_dout  (cmd_word),
		.o_valid (cmd_valid),
		.o_empty (cmd_empty),
		.o_full  ()
	);

	burst_packer #(.LANES(BURST_LEN), .AW(D_AW)) d_pack_i (
		.okClk(okClk), .i_rst(i_rst), .i_clr(i_buf_clr), .i_we(i_d_we), .i_val(i_d),
		.o_ram_we(d_we), .o_ram_addr(d_waddr), .o_ram_data(d_wdata)
	);

	burst_packer #(.LANES(BURST_LEN), .AW(W_AW)) w_pack_i (
		.okClk(okClk), .i_rst(i_rst), .i_clr(i_buf_clr), .i_we(i_w_we), .i_val(i_w),
		.o_ram_we(w_we), .o_ram_addr(w_waddr), .o_ram_data(w_wdata)
	);

	burst_packer #(.LANES(1), .AW(B_AW)) b_pack_i (	// one bias per word
		.okClk(okClk), .i_rst(i_rst), .i_clr(i_buf_clr), .i_we(i_b_we), .i_val(i_b),
		.o_ram_we(b_we), .o_ram_addr(b_waddr), .o_ram_data(b_wdata)
	);

	tile_ram #(.AW(D_AW), .DW(WORD_W)) d_ram_i (
		.okClk(okClk), .i_we(d_we), .i_waddr(d_waddr), .i_wdata(d_wdata),
		.i_raddr(d_raddr), .o_rdata(d_rdata)
	);

	tile_ram #(.AW(W_AW), .DW(WORD_W)) w_ram_i (
		.okClk(okClk), .i_we(w_we), .i_waddr(w_waddr), .i_wdata(w_wdata),
		.i_raddr(w_raddr), .o_rdata(w_rdata)
	);

	tile_ram #(.AW(B_AW), .DW(LANE_W)) b_ram_i (
		.okClk(okClk), .i_we(b_we), .i_waddr(b_waddr), .i_wdata(b_wdata),
		.i_raddr(b_raddr), .o_rdata(b_rdata)
	);

	csb csb_i (
		.okClk        (okClk),
		.i_rst        (i_rst),
		.i_cmd_empty  (cmd_empty),
		.o_cmd_pop    (cmd_pop),
		.i_cmd_valid  (cmd_valid),
		.i_cmd        (cmd_word),
		.cmd          (cmd_if.ctrl),
		.o_irq        (o_irq),
		.o_done_count (o_done_count)
	);

	gemm_engine engine_i (
		.okClk    (okClk),
		.i_rst    (i_rst),
		.cmd      (cmd_if.eng),
		.o_d_addr (d_raddr),
		.i_d_data (d_rdata),
		.o_w_addr (w_raddr),
		.i_w_data (w_rdata),
		.o_b_addr (b_raddr),
		.i_b_data (b_rdata),
		.o_res_we (res_we),
		.o_res    (res_data)
	);

	sync_fifo #(.payload_t(logic [LANE_W-1:0]), .DEPTH(RES_DEPTH)) res_fifo_i (
		.okClk   (okClk),
		.i_rst   (i_rst),
		.i_push  (res_we),
		.i_din   (res_data),
		.i_pop   (i_res_rd),
		.o_dout  (o_res),
		.o_valid (o_res_valid),
		.o_empty (o_res_empty),
		.o_full  ()
	);

endmodule

`default_nettype wire

// ==== gemm_engine.sv ====
`default_nettype none

module gemm_engine
	import accel_pkg::*;
(
	input  wire logic              okClk,
	input  wire logic              i_rst,
	layer_cmd_if.eng               cmd,
	output logic [D_AW-1:0]        o_d_addr,
	input  wire logic [WORD_W-1:0] i_d_data,
	output logic [W_AW-1:0]        o_w_addr,
	input  wire logic [WORD_W-1:0] i_w_data,
	output logic [B_AW-1:0]        o_b_addr,
	input  wire logic [LANE_W-1:0] i_b_data,
	output logic                   o_res_we,
	output logic [LANE_W-1:0]      o_res
);

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		DRAIN
	} state_t;

	state_t      state;
	layer_desc_t desc_q;
	logic [7:0]  burst_cnt;
	logic [7:0]  out_cnt;
	logic [W_AW-1:0] w_addr;
	logic        rd_last;
	logic        take_start;

	// pipe: s1 ram data, s2 accumulate, s3 result
	logic s1_v;
	logic s1_last;
	logic s2_v;
	logic s2_last;
	logic s3_v;

	logic signed [LANE_W-1:0] bias_q;
	logic signed [31:0] bias_ext;
	logic signed [31:0] lane_sum;
	logic signed [31:0] prod_sum;
	logic signed [31:0] acc;
	logic signed [31:0] acc_sh;
	logic [LANE_W-1:0]  res_nxt;

	assign cmd.busy   = (state != IDLE);
	assign take_start = (state == IDLE) && cmd.start;
	assign rd_last    = (burst_cnt == desc_q.n_in - 8'd1);

	assign o_d_addr = D_AW'(burst_cnt);
	assign o_w_addr = w_addr;	// weights of all outputs are contiguous
	assign o_b_addr = B_AW'(out_cnt);

	always_ff @(posedge okClk) begin
		if (i_rst) begin
			state     <= IDLE;
			burst_cnt <= '0;
			out_cnt   <= '0;
			cmd.done  <= 1'b0;
		end else begin
			cmd.done <= 1'b0;
			case (state)
				IDLE: begin
					if (cmd.start) begin
						burst_cnt <= '0;
						out_cnt   <= '0;
						state     <= ISSUE;
					end
				end
				ISSUE: begin
					if (rd_last) begin
						burst_cnt <= '0;
						state     <= DRAIN;
					end else begin
						burst_cnt <= burst_cnt + 8'd1;
					end
				end
				DRAIN: begin
					if (s3_v) begin	// result of this output is out
						if (out_cnt == desc_q.n_out - 8'd1) begin
							cmd.done <= 1'b1;
							state    <= IDLE;
						end else begin
							out_cnt <= out_cnt + 8'd1;
							state   <= ISSUE;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge okClk) begin
		if (take_start) begin
			desc_q <= cmd.desc;
			w_addr <= cmd.desc.w_base;
		end else if (state == ISSUE) begin
			w_addr <= w_addr + 1'b1;
		end
	end

	always_ff @(posedge okClk) begin
		if (i_rst) begin
			s1_v     <= 1'b0;
			s1_last  <= 1'b0;
			s2_v     <= 1'b0;
			s2_last  <= 1'b0;
			s3_v     <= 1'b0;
			o_res_we <= 1'b0;
		end else begin
			s1_v     <= (state == ISSUE);
			s1_last  <= (state == ISSUE) && rd_last;
			s2_v     <= s1_v;
			s2_last  <= s1_last;
			s3_v     <= s2_v && s2_last;
			o_res_we <= s3_v;
		end
	end

	// four lane multiply and add tree
	always_comb begin
		lane_sum = '0;
		for (int i = 0; i < BURST_LEN; i++) begin
			lane_sum = lane_sum + signed'(i_d_data[i*LANE_W +: LANE_W])
				* signed'(i_w_data[i*LANE_W +: LANE_W]);
		end
	end

	assign bias_ext = bias_q;	// sign extended

	always_ff @(posedge okClk) begin
		if (s1_v)
			prod_sum <= lane_sum;
		if (s1_last)
			bias_q <= signed'(i_b_data);	// bias addr held through the last read
		if (take_start || s3_v)
			acc <= '0;
		else if (s2_v)
			acc <= acc + prod_sum + (s2_last ? bias_ext : 32'sd0);
	end

	// shift the full sum, then keep the low lane
	assign acc_sh  = acc >>> desc_q.shift;
	assign res_nxt = (desc_q.op == OP_FC_RELU && acc_sh < 0) ? '0 : acc_sh[LANE_W-1:0];

	always_ff @(posedge okClk) begin
		if (s3_v)
			o_res <= res_nxt;
	end

	a_desc_sizes: assert property (@(posedge okClk) disable iff (i_rst)
		cmd.start |-> (cmd.desc.n_in != 8'd0 && cmd.desc.n_out != 8'd0))
		else $error("layer started with zero n_in or n_out");

endmodule

`default_nettype wire

// ==== csb.sv ====
`default_nettype none

module csb
	import accel_pkg::*;
(
	input  wire logic        okClk,
	input  wire logic        i_rst,
	input  wire logic        i_cmd_empty,
	output logic             o_cmd_pop,
	input  wire logic        i_cmd_valid,
	input  wire logic [31:0] i_cmd,
	layer_cmd_if.ctrl        cmd,
	output logic             o_irq,
	output logic [6:0]       o_done_count
);

	typedef enum logic [1:0] {
		FETCH,
		ISSUE,
		WAIT
	} state_t;

	state_t     state;
	logic [1:0] word_cnt;	// index of the word arriving from the fifo
	logic [1:0] pending;
	logic       last_word;

	// words received plus the one still in flight
	assign pending   = word_cnt + 2'(i_cmd_valid);
	assign o_cmd_pop = (state == FETCH) && !i_cmd_empty && (pending < 2'(CMD_WORDS));
	assign last_word = (word_cnt == 2'(CMD_WORDS - 1));

	assign cmd.start = (state == ISSUE) && !cmd.busy;

	always_ff @(posedge okClk) begin
		if (i_rst) begin
			state        <= FETCH;
			word_cnt     <= '0;
			o_irq        <= 1'b0;
			o_done_count <= '0;
		end else begin
			o_irq <= 1'b0;
			case (state)
				FETCH: begin
					if (i_cmd_valid) begin
						if (last_word) begin
							word_cnt <= '0;
							state    <= ISSUE;
						end else begin
							word_cnt <= word_cnt + 1'b1;
						end
					end
				end
				ISSUE: begin
					if (cmd.start)
						state <= WAIT;
				end
				WAIT: begin
					if (cmd.done) begin
						o_irq        <= 1'b1;
						o_done_count <= o_done_count + 7'd1;
						state        <= FETCH;
					end
				end
				default: state <= FETCH;
			endcase
		end
	end

	// field decode, held until the next command is fetched
	always_ff @(posedge okClk) begin
		if (i_cmd_valid) begin
			if (word_cnt == 2'd0) begin
				cmd.desc.op    <= op_t'(i_cmd[OP_LSB +: 3]);
				cmd.desc.shift <= i_cmd[SHIFT_LSB +: 5];
				cmd.desc.n_in  <= i_cmd[NIN_LSB +: 8];
				cmd.desc.n_out <= i_cmd[NOUT_LSB +: 8];
			end else begin
				cmd.desc.w_base <= i_cmd[WBASE_LSB +: W_AW];
			end
		end
	end

	// engine must pick up every start and report busy right after it
	a_start_idle: assert property (@(posedge okClk) disable iff (i_rst)
		cmd.start |-> (!cmd.busy ##1 cmd.busy))
		else $error("start issued to a busy engine or not taken");

endmodule

`default_nettype wire

// ==== tile_ram.sv ====
`default_nettype none

module tile_ram #(
	parameter int AW = 8,
	parameter int DW = 64
) (
	input  wire logic          okClk,
	input  wire logic          i_we,
	input  wire logic [AW-1:0] i_waddr,
	input  wire logic [DW-1:0] i_wdata,
	input  wire logic [AW-1:0] i_raddr,
	output logic [DW-1:0]      o_rdata
);

	logic [DW-1:0] mem [2**AW];

	always_ff @(posedge okClk) begin
		if (i_we)
			mem[i_waddr] <= i_wdata;
		o_rdata <= mem[i_raddr];	// registered read, old data on collision
	end

endmodule

`default_nettype wire

// ==== burst_packer.sv ====
`default_nettype none

module burst_packer
	import accel_pkg::*;
#(
	parameter int LANES = BURST_LEN,
	parameter int AW    = D_AW
) (
	input  wire logic              okClk,
	input  wire logic              i_rst,
	input  wire logic              i_clr,
	input  wire logic              i_we,
	input  wire logic [LANE_W-1:0] i_val,
	output logic                   o_ram_we,
	output logic [AW-1:0]          o_ram_addr,
	output logic [LANES*LANE_W-1:0] o_ram_data
);

	localparam int DW = LANES * LANE_W;
	localparam int CW = (LANES > 1) ? $clog2(LANES) : 1;

	logic [CW-1:0] lane_cnt;
	logic [DW-1:0] shreg;
	logic          burst_full;

	assign burst_full = (lane_cnt == CW'(LANES - 1));	// strobe completes a word
	assign o_ram_data = shreg;

	always_ff @(posedge okClk) begin
		if (i_rst) begin
			lane_cnt   <= '0;
			o_ram_addr <= '0;
			o_ram_we   <= 1'b0;
		end else begin
			o_ram_we <= i_we && burst_full && !i_clr;
			if (i_clr) begin
				lane_cnt   <= '0;
				o_ram_addr <= '0;
			end else begin
				if (o_ram_we)
					o_ram_addr <= o_ram_addr + 1'b1;	// bump after the write
				if (i_we)
					lane_cnt <= burst_full ? '0 : lane_cnt + 1'b1;
			end
		end
	end

	// new value enters the top lane, first value ends in lane 0
	always_ff @(posedge okClk) begin
		if (i_we)
			shreg <= DW'({i_val, shreg} >> LANE_W);
	end

endmodule

`default_nettype wire

// ==== sync_fifo.sv ====
`default_nettype none

module sync_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int  DEPTH     = 16
) (
	input  wire logic     okClk,
	input  wire logic     i_rst,
	input  wire logic     i_push,
	input  wire payload_t i_din,
	input  wire logic     i_pop,
	output payload_t      o_dout,
	output logic          o_valid,
	output logic          o_empty,
	output logic          o_full
);

	localparam int AW = $clog2(DEPTH);

	payload_t mem [DEPTH];
	logic [AW-1:0] wptr;
	logic [AW-1:0] rptr;
	logic [AW:0]   count;	// occupancy with one extra bit for full
	logic          pop_ok;

	assign o_empty = (count == '0);
	assign o_full  = (count == (AW+1)'(DEPTH));
	assign pop_ok  = i_pop && !o_empty;

	always_ff @(posedge okClk) begin
		if (i_rst) begin
			wptr    <= '0;
			rptr    <= '0;
			count   <= '0;
			o_valid <= 1'b0;
		end else begin
			o_valid <= pop_ok;
			if (i_push)
				wptr <= wptr + 1'b1;
			if (pop_ok)
				rptr <= rptr + 1'b1;
			case ({i_push, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge okClk) begin
		if (i_push)
			mem[wptr] <= i_din;
		if (pop_ok)
			o_dout <= mem[rptr];	// one cycle read latency
	end

	// no back-pressure so the producer must watch the level
	a_no_overflow: assert property (@(posedge okClk) disable iff (i_rst)
		!(i_push && o_full))
		else $error("push into a full fifo");

	a_no_underflow: assert property (@(posedge okClk) disable iff (i_rst)
		!(i_pop && o_empty))
		else $error("pop from an empty fifo");

endmodule

`default_nettype wire

// ==== layer_cmd_if.sv ====
`default_nettype none

interface layer_cmd_if
	import accel_pkg::*;
();

	logic        start;	// one cycle strobe from csb
	layer_desc_t desc;	// sampled while start is high
	logic        busy;
	logic        done;	// one cycle strobe from the engine

	modport ctrl (output start, output desc, input busy, input done);
	modport eng (input start, input desc, output busy, output done);

endinterface

`default_nettype wire

// ==== accel_pkg.sv ====
`default_nettype none

package accel_pkg;

	localparam int BURST_LEN = 4;	// lanes per buffer word
	localparam int LANE_W    = 16;
	localparam int WORD_W    = BURST_LEN * LANE_W;

	localparam int D_AW = 8;	// data ram
	localparam int W_AW = 12;	// weight ram
	localparam int B_AW = 8;	// bias ram

	localparam int CMD_DEPTH = 16;
	localparam int RES_DEPTH = 256;
	localparam int CMD_WORDS = 2;	// command words per layer

	// word 0 field positions
	localparam int OP_LSB    = 29;
	localparam int SHIFT_LSB = 24;
	localparam int NIN_LSB   = 8;
	localparam int NOUT_LSB  = 0;
	// word 1
	localparam int WBASE_LSB = 0;

	typedef enum logic [2:0] {
		OP_FC      = 3'd0,
		OP_FC_RELU = 3'd1
	} op_t;

	typedef struct packed {
		op_t        op;
		logic [4:0] shift;	// arithmetic right shift of the sum
		logic [7:0] n_in;	// input bursts per output
		logic [7:0] n_out;	// outputs in the layer
		logic [W_AW-1:0] w_base;
	} layer_desc_t;

endpackage

`default_nettype wire
